//--- design/owt_pkg.sv
//======================================================================
// shared widths, types and encodings of the one-wire receiver
// a frame is command, data and crc, sent msb first as Manchester bits
// crc-8 starts from zero and has no final xor
// symbol counter width limits the half-bit time to about 60 cycles
//======================================================================
`default_nettype none

package owt_pkg;

    // field widths
    localparam int OWT_CMD_BITS   = 8;
    localparam int OWT_DATA_BITS  = 16;
    localparam int OWT_CRC_BITS   = 8;
    localparam int OWT_FRAME_BITS = OWT_CMD_BITS + OWT_DATA_BITS + OWT_CRC_BITS;

    // rising edges in the sync head
    localparam int OWT_SYNC_EDGES = 10;

    // edge interval counter width
    localparam int OWT_SYM_CNT_W  = 8;

    typedef logic [OWT_CMD_BITS-1:0]  owt_cmd_t;
    typedef logic [OWT_DATA_BITS-1:0] owt_data_t;
    typedef logic [OWT_CRC_BITS-1:0]  owt_crc_t;

    // x^8 + x^2 + x + 1
    localparam owt_crc_t OWT_CRC_POLY = 8'h07;

    typedef enum logic [1:0] {
        IDLE,
        SYNC_HEAD,
        SYNC_TAIL,
        BITS
    } owt_rx_state_e;

    // edge interval in units of the half-bit time
    typedef enum logic [1:0] {
        SYM_NONE,
        SYM_ONE,
        SYM_TWO,
        SYM_THREE
    } owt_symbol_e;

endpackage

`default_nettype wire

//--- design/owt_symbol_decoder.sv
//======================================================================
// line sync, symbol length learning and Manchester bit decoding
// learns the bit period from the sync head and needs T of 4 to 60 cycles
// a line edge gives its bit strobe 4 cycles later
// a stall in the sync head or tail drops back to idle without a report
// stays in BITS until the supervisor closes the frame
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module owt_symbol_decoder
    import owt_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_owt_rx,
    input  logic i_frame_close,
    output logic o_frame_start,
    output logic o_bit_vld,
    output logic o_bit,
    output logic o_code_err
);

    localparam int W      = OWT_SYM_CNT_W;
    localparam int HEAD_W = $clog2(OWT_SYNC_EDGES + 1);
    localparam logic [W-1:0] CNT_MAX = {W{1'b1}};

    owt_rx_state_e     state_q;
    owt_symbol_e       sym;
    logic              sync1_q;
    logic              sync2_q;
    logic              sync3_q;
    logic              edge_q;
    logic              rise_q;
    logic [W-1:0]      cnt_q;
    logic [W-1:0]      iv_q;
    logic [W-1:0]      last_iv_q;
    logic [W-1:0]      avg_q;
    logic [HEAD_W-1:0] head_cnt_q;
    logic              first_q;
    logic              at_mid_q;
    logic [W:0]        sample;
    logic [W:0]        avg_sum;
    logic [W:0]        th_one;
    logic [W:0]        th_two;
    logic [W:0]        th_three;

    //==================================================================
    // synchronizer, edge register and interval counter
    //==================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync1_q <= 1'b0;
            sync2_q <= 1'b0;
            sync3_q <= 1'b0;
            edge_q  <= 1'b0;
            rise_q  <= 1'b0;
            cnt_q   <= '0;
            iv_q    <= '0;
        end else begin
            sync1_q <= i_owt_rx;
            sync2_q <= sync1_q;
            sync3_q <= sync2_q;
            edge_q  <= sync2_q ^ sync3_q;
            rise_q  <= sync2_q;
            if (sync2_q ^ sync3_q) begin
                cnt_q <= W'(1);
                iv_q  <= cnt_q;
            end else if (cnt_q != CNT_MAX) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // one rising-edge period is the high plus the low interval
    assign sample  = {1'b0, last_iv_q} + {1'b0, iv_q};
    assign avg_sum = {1'b0, avg_q} + sample;

    // bounds at 0.75, 1.25 and 1.75 of the learned period
    assign th_one   = {1'b0, avg_q} - {3'b000, avg_q[W-1:2]};
    assign th_two   = {1'b0, avg_q} + {3'b000, avg_q[W-1:2]};
    assign th_three = {avg_q, 1'b0} - {3'b000, avg_q[W-1:2]};

    always_comb begin
        if ({1'b0, iv_q} <= th_one) begin
            sym = SYM_ONE;
        end else if ({1'b0, iv_q} <= th_two) begin
            sym = SYM_TWO;
        end else if ({1'b0, iv_q} <= th_three) begin
            sym = SYM_THREE;
        end else begin
            sym = SYM_NONE;
        end
    end

    //==================================================================
    // frame FSM and bit classify register
    //==================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q       <= IDLE;
            head_cnt_q    <= '0;
            avg_q         <= '0;
            last_iv_q     <= '0;
            first_q       <= 1'b0;
            at_mid_q      <= 1'b0;
            o_frame_start <= 1'b0;
            o_bit_vld     <= 1'b0;
            o_bit         <= 1'b0;
            o_code_err    <= 1'b0;
        end else begin
            o_frame_start <= 1'b0;
            o_bit_vld     <= 1'b0;
            o_code_err    <= 1'b0;
            if (edge_q) begin
                last_iv_q <= iv_q;
            end
            if (i_frame_close) begin
                state_q <= IDLE;
            end else begin
                case (state_q)
                    IDLE: begin
                        // only a rising edge opens a frame
                        if (edge_q && rise_q) begin
                            state_q    <= SYNC_HEAD;
                            head_cnt_q <= HEAD_W'(1);
                        end
                    end
                    SYNC_HEAD: begin
                        if (cnt_q == CNT_MAX) begin
                            state_q <= IDLE;
                        end else if (edge_q && rise_q) begin
                            head_cnt_q <= head_cnt_q + 1'b1;
                            if (head_cnt_q == HEAD_W'(1)) begin
                                avg_q <= sample[W-1:0];
                            end else begin
                                avg_q <= avg_sum[W:1];
                            end
                            if (head_cnt_q == HEAD_W'(OWT_SYNC_EDGES - 1)) begin
                                state_q <= SYNC_TAIL;
                            end
                        end
                    end
                    SYNC_TAIL: begin
                        // tail ends on the falling edge after its 2T high
                        if (cnt_q == CNT_MAX) begin
                            state_q <= IDLE;
                        end else if (edge_q && !rise_q && sym == SYM_TWO) begin
                            state_q       <= BITS;
                            o_frame_start <= 1'b1;
                            first_q       <= 1'b1;
                            at_mid_q      <= 1'b0;
                        end
                    end
                    BITS: begin
                        if (edge_q) begin
                            first_q <= 1'b0;
                            if (first_q) begin
                                // 2T rise opens a one, 3T rise is the middle of a zero
                                if (rise_q && sym == SYM_TWO) begin
                                    at_mid_q <= 1'b0;
                                end else if (rise_q && sym == SYM_THREE) begin
                                    o_bit_vld <= 1'b1;
                                    o_bit     <= 1'b0;
                                    at_mid_q  <= 1'b1;
                                end else begin
                                    o_code_err <= 1'b1;
                                end
                            end else if (sym == SYM_ONE) begin
                                at_mid_q  <= !at_mid_q;
                                o_bit_vld <= !at_mid_q;
                                o_bit     <= !rise_q;
                            end else if (sym == SYM_TWO && at_mid_q) begin
                                o_bit_vld <= 1'b1;
                                o_bit     <= !rise_q;
                            end else begin
                                o_code_err <= 1'b1;
                            end
                        end
                    end
                    default: begin
                        state_q <= IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- design/owt_field_parser.sv
//======================================================================
// steers decoded bits into the command and data fields
// fields shift in msb first and hold their value until the next frame
// crc bits are counted here and checked in the crc block
// bits outside an open frame are dropped
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module owt_field_parser
    import owt_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_frame_start,
    input  logic      i_frame_close,
    input  logic      i_bit_vld,
    input  logic      i_bit,
    output owt_cmd_t  o_cmd,
    output owt_data_t o_data,
    output logic      o_fields_done
);

    localparam int CNT_W = $clog2(OWT_FRAME_BITS + 1);

    logic [CNT_W-1:0] bit_cnt_q;
    logic             active_q;
    logic             take;
    logic             last_bit;

    assign take     = active_q & i_bit_vld;
    assign last_bit = (bit_cnt_q == CNT_W'(OWT_FRAME_BITS - 1));

    //==================================================================
    // bit counter and completion strobe
    //==================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active_q      <= 1'b0;
            bit_cnt_q     <= '0;
            o_fields_done <= 1'b0;
        end else begin
            o_fields_done <= take & last_bit;
            if (i_frame_start) begin
                active_q  <= 1'b1;
                bit_cnt_q <= '0;
            end else if (i_frame_close) begin
                active_q <= 1'b0;
            end else if (take) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
                if (last_bit) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    //==================================================================
    // field shift registers
    //==================================================================
    always_ff @(posedge i_clk) begin
        if (take) begin
            if (bit_cnt_q < CNT_W'(OWT_CMD_BITS)) begin
                o_cmd <= {o_cmd[OWT_CMD_BITS-2:0], i_bit};
            end else if (bit_cnt_q < CNT_W'(OWT_CMD_BITS + OWT_DATA_BITS)) begin
                o_data <= {o_data[OWT_DATA_BITS-2:0], i_bit};
            end
        end
    end

endmodule

`default_nettype wire

//--- design/owt_crc8_checker.sv
//======================================================================
// serial crc-8 over command, data and the received crc
// a good frame leaves a zero remainder after its last bit
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module owt_crc8_checker
    import owt_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_frame_start,
    input  logic i_bit_vld,
    input  logic i_bit,
    output logic o_crc_ok
);

    owt_crc_t crc_q;
    logic     fb;

    assign fb = crc_q[OWT_CRC_BITS-1] ^ i_bit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            crc_q <= '0;
        end else if (i_frame_start) begin
            crc_q <= '0;
        end else if (i_bit_vld) begin
            crc_q <= {crc_q[OWT_CRC_BITS-2:0], 1'b0} ^ (fb ? OWT_CRC_POLY : '0);
        end
    end

    assign o_crc_ok = (crc_q == '0);

endmodule

`default_nettype wire

//--- design/owt_link_supervisor.sv
//======================================================================
// frame timeout, frame report and link error counter
// timeout runs from frame start and needs the bit field to fit inside
// code error or timeout gives done 2 cycles later with status 1
// com_err is high while the error count is at or above the threshold
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module owt_link_supervisor #(
    parameter int RX_TMO_CYC = 4000,
    parameter int ERR_INIT   = 8,
    parameter int ERR_MAX    = 15,
    parameter int ERR_ADD    = 4,
    parameter int ERR_SUB    = 1,
    parameter int ERR_THRESH = 4
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_frame_start,
    input  logic i_fields_done,
    input  logic i_crc_ok,
    input  logic i_code_err,
    output logic o_frame_close,
    output logic o_rx_done,
    output logic o_rx_status,
    output logic o_com_err
);

    localparam int TMO_W = $clog2(RX_TMO_CYC + 1);
    localparam int ERR_W = $clog2(ERR_MAX + 1);

    logic             active_q;
    logic [TMO_W-1:0] tmo_cnt_q;
    logic             tmo_hit;
    logic             abort_q;
    logic             frame_end;
    logic             frame_bad;
    logic [ERR_W-1:0] err_cnt_q;
    logic [ERR_W-1:0] err_cnt_nxt;
    logic [ERR_W:0]   err_sum;

    assign tmo_hit   = active_q & (tmo_cnt_q == TMO_W'(RX_TMO_CYC - 1));
    assign frame_end = active_q & (i_fields_done | abort_q);
    assign frame_bad = abort_q | ~i_crc_ok;
    assign err_sum   = {1'b0, err_cnt_q} + (ERR_W + 1)'(ERR_ADD);

    // saturating up on a bad frame, floored down on a good one
    always_comb begin
        err_cnt_nxt = err_cnt_q;
        if (frame_end && frame_bad) begin
            if (err_sum >= (ERR_W + 1)'(ERR_MAX)) begin
                err_cnt_nxt = ERR_W'(ERR_MAX);
            end else begin
                err_cnt_nxt = err_sum[ERR_W-1:0];
            end
        end else if (frame_end) begin
            if (err_cnt_q <= ERR_W'(ERR_SUB)) begin
                err_cnt_nxt = '0;
            end else begin
                err_cnt_nxt = err_cnt_q - ERR_W'(ERR_SUB);
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active_q      <= 1'b0;
            tmo_cnt_q     <= '0;
            abort_q       <= 1'b0;
            o_frame_close <= 1'b0;
            o_rx_done     <= 1'b0;
            o_rx_status   <= 1'b0;
            err_cnt_q     <= ERR_W'(ERR_INIT);
            o_com_err     <= (ERR_INIT >= ERR_THRESH);
        end else begin
            abort_q       <= tmo_hit | (active_q & i_code_err);
            o_frame_close <= frame_end;
            o_rx_done     <= frame_end;
            o_rx_status   <= frame_end & frame_bad;
            err_cnt_q     <= err_cnt_nxt;
            o_com_err     <= (err_cnt_nxt >= ERR_W'(ERR_THRESH));
            if (i_frame_start) begin
                active_q  <= 1'b1;
                tmo_cnt_q <= '0;
            end else if (frame_end) begin
                active_q <= 1'b0;
            end else if (active_q) begin
                tmo_cnt_q <= tmo_cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/owt_rx_top.sv
//======================================================================
// one-wire receiver top level
// done follows the line edge of the last bit by 6 cycles
// command and data hold the last received values until the next frame
// one frame at a time with no back-pressure
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module owt_rx_top
    import owt_pkg::*;
#(
    parameter int RX_TMO_CYC = 4000,
    parameter int ERR_INIT   = 8,
    parameter int ERR_MAX    = 15,
    parameter int ERR_ADD    = 4,
    parameter int ERR_SUB    = 1,
    parameter int ERR_THRESH = 4
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_owt_rx,
    output logic      o_rx_done,
    output logic      o_rx_status,
    output owt_cmd_t  o_rx_cmd,
    output owt_data_t o_rx_data,
    output logic      o_com_err
);

    logic frame_start;
    logic frame_close;
    logic bit_vld;
    logic rx_bit;
    logic code_err;
    logic fields_done;
    logic crc_ok;

    owt_symbol_decoder u_decoder (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_owt_rx      (i_owt_rx),
        .i_frame_close (frame_close),
        .o_frame_start (frame_start),
        .o_bit_vld     (bit_vld),
        .o_bit         (rx_bit),
        .o_code_err    (code_err)
    );

    owt_field_parser u_parser (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_start (frame_start),
        .i_frame_close (frame_close),
        .i_bit_vld     (bit_vld),
        .i_bit         (rx_bit),
        .o_cmd         (o_rx_cmd),
        .o_data        (o_rx_data),
        .o_fields_done (fields_done)
    );

    owt_crc8_checker u_crc (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_start (frame_start),
        .i_bit_vld     (bit_vld),
        .i_bit         (rx_bit),
        .o_crc_ok      (crc_ok)
    );

    owt_link_supervisor #(
        .RX_TMO_CYC (RX_TMO_CYC),
        .ERR_INIT   (ERR_INIT),
        .ERR_MAX    (ERR_MAX),
        .ERR_ADD    (ERR_ADD),
        .ERR_SUB    (ERR_SUB),
        .ERR_THRESH (ERR_THRESH)
    ) u_supervisor (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_start (frame_start),
        .i_fields_done (fields_done),
        .i_crc_ok      (crc_ok),
        .i_code_err    (code_err),
        .o_frame_close (frame_close),
        .o_rx_done     (o_rx_done),
        .o_rx_status   (o_rx_status),
        .o_com_err     (o_com_err)
    );

endmodule

`default_nettype wire

//--- tb/owt_frame_table.svh
//======================================================================
// test frames for the one-wire receiver testbench
// one column per array, one entry per frame, applied in order
// a random entry replaces command and data from the seeded generator
// expected status is 1 for a corrupted crc or a stalled frame
//======================================================================
`ifndef OWT_FRAME_TABLE_SVH
`define OWT_FRAME_TABLE_SVH

localparam int NUM_FRAMES = 9;

// half-bit time in clock cycles
localparam int TBL_T [NUM_FRAMES] = '{8, 4, 30, 8, 12, 8, 8, 16, 6};

// command and data sent on the line
localparam owt_cmd_t TBL_CMD [NUM_FRAMES] = '{
    8'hA5, 8'hA5, 8'hA5, 8'h00, 8'h00, 8'h3C, 8'h5A, 8'hC3, 8'h00
};
localparam owt_data_t TBL_DATA [NUM_FRAMES] = '{
    16'h1234, 16'h1234, 16'h1234, 16'h0000, 16'h0000,
    16'hBEEF, 16'hF00D, 16'h0F0F, 16'h0000
};

// random payload, crc bit flip, stall after the command
localparam bit TBL_RND   [NUM_FRAMES] = '{0, 0, 0, 1, 1, 0, 0, 0, 1};
localparam bit TBL_CRC   [NUM_FRAMES] = '{0, 0, 0, 0, 0, 1, 0, 0, 0};
localparam bit TBL_STALL [NUM_FRAMES] = '{0, 0, 0, 0, 0, 0, 1, 0, 0};

// expected o_rx_status at done
localparam bit TBL_STATUS [NUM_FRAMES] = '{0, 0, 0, 0, 0, 1, 1, 0, 0};

`endif

//--- tb/tb_owt_rx.sv
//======================================================================
// testbench for the one-wire receiver top level
// drives whole frames from the table and checks every done report
// keeps its own model of the link error counter
// stops at the first mismatch
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_owt_rx
    import owt_pkg::*;
;

    localparam int RX_TMO_CYC    = 4000;
    localparam int ERR_INIT      = 8;
    localparam int ERR_MAX       = 15;
    localparam int ERR_ADD       = 4;
    localparam int ERR_SUB       = 1;
    localparam int ERR_THRESH    = 4;
    localparam int GAP_CYC       = 40;
    localparam int HOLD_CYC      = 200;
    localparam int DONE_WAIT_CYC = RX_TMO_CYC + 100;
    // sync, frame start and report stages around the timeout
    localparam int TMO_SLACK_CYC = 10;

    `include "owt_frame_table.svh"

    logic      clk;
    logic      rst_n;
    logic      owt_rx;
    logic      rx_done;
    logic      rx_status;
    owt_cmd_t  rx_cmd;
    owt_data_t rx_data;
    logic      com_err;

    // values captured by the done monitor
    int        done_cnt = 0;
    int        cyc_cnt  = 0;
    int        cap_cyc;
    logic      cap_status;
    owt_cmd_t  cap_cmd;
    owt_data_t cap_data;
    logic      cap_com_err;

    int        seed = 32'h62bc6659;
    int        err_model;

    owt_rx_top #(
        .RX_TMO_CYC (RX_TMO_CYC),
        .ERR_INIT   (ERR_INIT),
        .ERR_MAX    (ERR_MAX),
        .ERR_ADD    (ERR_ADD),
        .ERR_SUB    (ERR_SUB),
        .ERR_THRESH (ERR_THRESH)
    ) uut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_owt_rx    (owt_rx),
        .o_rx_done   (rx_done),
        .o_rx_status (rx_status),
        .o_rx_cmd    (rx_cmd),
        .o_rx_data   (rx_data),
        .o_com_err   (com_err)
    );

    always #2 clk = ~clk;

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        cyc_cnt = cyc_cnt + 1;
        if (rx_done) begin
            done_cnt    = done_cnt + 1;
            cap_cyc     = cyc_cnt;
            cap_status  = rx_status;
            cap_cmd     = rx_cmd;
            cap_data    = rx_data;
            cap_com_err = com_err;
        end
    end

    //==================================================================
    // failure handling and compare tasks
    //==================================================================
    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_cmd(input string name, input owt_cmd_t exp, input owt_cmd_t act);
        if (act !== exp) begin
            $display("ERROR %s: cmd expected 0x%h, actual 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_data(input string name, input owt_data_t exp, input owt_data_t act);
        if (act !== exp) begin
            $display("ERROR %s: data expected 0x%h, actual 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: status expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_com_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: com_err expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // a stalled frame ends on the timeout counted from frame start
    task automatic check_tmo_delay(input string name, input int act);
        if (act < RX_TMO_CYC || act > RX_TMO_CYC + TMO_SLACK_CYC) begin
            $display("ERROR %s: done delay expected %0d to %0d cycles, actual %0d",
                     name, RX_TMO_CYC, RX_TMO_CYC + TMO_SLACK_CYC, act);
            abort_run();
        end
    endtask

    //==================================================================
    // line generator
    //==================================================================
    // byte-wise crc-8 over command and data, msb first
    function automatic owt_crc_t crc8_of(input owt_cmd_t cmd, input owt_data_t data);
        logic [7:0] bytes [3];
        owt_crc_t   crc;
        int         b;
        int         i;
        bytes[0] = cmd;
        bytes[1] = data[15:8];
        bytes[2] = data[7:0];
        crc = '0;
        for (b = 0; b < 3; b++) begin
            crc = crc ^ bytes[b];
            for (i = 0; i < 8; i++) begin
                if (crc[7]) begin
                    crc = {crc[6:0], 1'b0} ^ OWT_CRC_POLY;
                end else begin
                    crc = {crc[6:0], 1'b0};
                end
            end
        end
        return crc;
    endfunction

    task automatic hold_line(input logic level, input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(posedge clk);
            owt_rx <= level;
        end
    endtask

    task automatic send_frame(input int t, input owt_cmd_t cmd, input owt_data_t data,
                              input bit crc_bad, input bit stall, output int tail_cyc);
        logic [OWT_FRAME_BITS-1:0] bits;
        owt_crc_t                  crc;
        int                        i;
        crc = crc8_of(cmd, data);
        if (crc_bad) begin
            crc = crc ^ 8'h01;
        end
        bits = {cmd, data, crc};
        for (i = 0; i < OWT_SYNC_EDGES; i++) begin
            hold_line(1'b1, t);
            hold_line(1'b0, t);
        end
        hold_line(1'b1, 2 * t);
        // the tail falling edge goes out on the next clock
        tail_cyc = cyc_cnt;
        hold_line(1'b0, 2 * t);
        i = OWT_FRAME_BITS - 1;
        // a stalled frame ends after the command bits
        while (i >= 0 && !(stall && i < OWT_FRAME_BITS - OWT_CMD_BITS)) begin
            hold_line(bits[i], t);
            hold_line(!bits[i], t);
            i--;
        end
        hold_line(stall, 1);
    endtask

    task automatic wait_done(input int prev, input string name);
        int n;
        n = 0;
        while (done_cnt == prev && n < DONE_WAIT_CYC) begin
            @(posedge clk);
            n++;
        end
        if (done_cnt == prev) begin
            $display("ERROR %s: no done pulse within %0d cycles", name, DONE_WAIT_CYC);
            abort_run();
        end
    endtask

    task automatic update_err_model(input logic bad);
        if (bad) begin
            err_model = (err_model + ERR_ADD > ERR_MAX) ? ERR_MAX : err_model + ERR_ADD;
        end else begin
            err_model = (err_model < ERR_SUB) ? 0 : err_model - ERR_SUB;
        end
    endtask

    function automatic int run_limit();
        int total;
        int k;
        total = 16 + 100;
        for (k = 0; k < NUM_FRAMES; k++) begin
            total += (2 * OWT_SYNC_EDGES + 4 + 2 * OWT_FRAME_BITS) * TBL_T[k];
            total += RX_TMO_CYC + GAP_CYC + HOLD_CYC;
        end
        return total + total / 4;
    endfunction

    // watchdog
    initial begin
        repeat (run_limit()) @(posedge clk);
        $display("ERROR watchdog: run did not finish within %0d cycles", run_limit());
        abort_run();
    end

    //==================================================================
    // table loop
    //==================================================================
    initial begin
        int          k;
        int          prev;
        int          tail_cyc;
        logic [31:0] rnd;
        owt_cmd_t    cmd;
        owt_data_t   data;
        string       name;
        clk       = 1'b0;
        rst_n     = 1'b0;
        owt_rx    = 1'b0;
        err_model = ERR_INIT;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_com_err("after reset", 1'b1, com_err);
        check_status("after reset", 1'b0, rx_status);
        if (rx_done !== 1'b0) begin
            $display("ERROR after reset: done is high with no frame sent");
            abort_run();
        end
        hold_line(1'b0, GAP_CYC);
        for (k = 0; k < NUM_FRAMES; k++) begin
            name = $sformatf("frame %0d (T=%0d)", k, TBL_T[k]);
            cmd  = TBL_CMD[k];
            data = TBL_DATA[k];
            if (TBL_RND[k]) begin
                rnd  = $random(seed);
                cmd  = rnd[7:0];
                rnd  = $random(seed);
                data = rnd[15:0];
            end
            prev = done_cnt;
            send_frame(TBL_T[k], cmd, data, TBL_CRC[k], TBL_STALL[k], tail_cyc);
            wait_done(prev, name);
            if (TBL_STALL[k]) begin
                hold_line(1'b1, HOLD_CYC);
            end
            hold_line(1'b0, GAP_CYC);
            if (done_cnt != prev + 1) begin
                $display("ERROR %s: %0d done pulses seen, one expected", name, done_cnt - prev);
                abort_run();
            end
            if (TBL_STALL[k]) begin
                check_tmo_delay(name, cap_cyc - tail_cyc);
            end
            check_status(name, TBL_STATUS[k], cap_status);
            check_cmd(name, cmd, cap_cmd);
            if (!TBL_STALL[k]) begin
                check_data(name, data, cap_data);
            end
            update_err_model(TBL_STATUS[k]);
            check_com_err(name, (err_model >= ERR_THRESH), cap_com_err);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+tb
design/owt_pkg.sv
design/owt_symbol_decoder.sv
design/owt_field_parser.sv
design/owt_crc8_checker.sv
design/owt_link_supervisor.sv
design/owt_rx_top.sv
tb/tb_owt_rx.sv

//--- run_sim.sh
#!/bin/sh
# build and run the one-wire receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_owt_rx -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_owt_rx > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "simulation passed"
exit 0
